/* verilog.f */
hw/frame_pkg.sv
hw/dsp_pkg.sv
hw/pulse_detector.sv
hw/frame_sequencer.sv
hw/symbol_correlator.sv
hw/code_packer.sv
hw/ppm_decoder_top.sv
dv/ppm_decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
        -f verilog.f --top-module ppm_decoder_tb -o ppm_decoder_sim > build.log 2>&1 \
        && ./obj_dir/ppm_decoder_sim > sim.log 2>&1 \
        || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }

/* dv/ppm_decoder_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ppm_decoder_tb;

        import frame_pkg::*;
        import dsp_pkg::*;

        localparam int ROWS         = 5;
        localparam int IDLE_GAP     = 200;
        localparam int LIMIT_CYCLES = 2 * ROWS * 9800;

        localparam int KIND_GOOD    = 0;
        localparam int KIND_MISSING = 1;
        localparam int KIND_EN_LOW  = 2;

        localparam sample_t LEVEL_IDLE  = 8'd10;
        localparam sample_t LEVEL_HIGH  = 8'd90;
        localparam sample_t LEVEL_PULSE = 8'd120;

        logic        clk;
        logic        rst_n;
        logic        en;
        sample_t     data_in;
        frame_word_t data_out;
        logic        frame_valid;

        // one row per frame
        int                      kind_tab [ROWS];
        logic                    expect_tab [ROWS];
        logic [DATA_SYMBOLS-1:0] pattern_tab [ROWS];

        longint      cycle_count = 0;
        longint      last_data_cycle = 0;
        longint      valid_cycle = 0;
        int          valid_total = 0;
        frame_word_t valid_word = '0;
        int          errors = 0;
        int          row_errors = 0;
        int          passed_tests = 0;

        ppm_decoder_top dut (
                .clk         (clk),
                .rst_n       (rst_n),
                .en          (en),
                .data_in     (data_in),
                .data_out    (data_out),
                .frame_valid (frame_valid)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        always @(posedge clk)
                cycle_count <= cycle_count + 1;

        // outputs settle after the rising edge, look at them on the falling one
        always @(negedge clk) begin
                if (frame_valid) begin
                        valid_total = valid_total + 1;
                        valid_cycle = cycle_count;
                        valid_word  = data_out;
                end
        end

        initial begin
                repeat (LIMIT_CYCLES) @(posedge clk);
                $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
                $display("TEST FAILED");
                $finish;
        end

        ////////////////////
        // stimulus model
        ////////////////////

        // sel set puts the high level on the first half
        function automatic sample_t data_level(logic sel, int i);
                logic first_half;
                first_half = (i < int'(SAMPLES_PER_SYMBOL) / 2);
                return (first_half == sel) ? LEVEL_HIGH : LEVEL_IDLE;
        endfunction

        // pulses at the start of symbols 0 and 1, mid symbol in 3 and 4
        function automatic sample_t preamble_level(int sym, int i, int kind);
                int pulse_at;
                pulse_at = -1;
                if (sym == 0 || sym == 1)
                        pulse_at = 0;
                else if (sym == 4 || (sym == 3 && kind != KIND_MISSING))
                        pulse_at = 40;
                if (pulse_at >= 0 && (i == pulse_at || i == pulse_at + 1))
                        return LEVEL_PULSE;
                return LEVEL_IDLE;
        endfunction

        function automatic sym_code_t model_code(logic sel);
                int sum;
                sum = 0;
                for (int i = 0; i < int'(SAMPLES_PER_SYMBOL); i++) begin
                        if (CORR_TEMPLATE[i])
                                sum = sum + int'(data_level(sel, i));
                        else
                                sum = sum - int'(data_level(sel, i));
                end
                return (sum > DECISION_THRESHOLD_DEFAULT) ? CODE_HIGH : CODE_LOW;
        endfunction

        // first data symbol in bits 1:0
        function automatic frame_word_t model_word(logic [DATA_SYMBOLS-1:0] pattern);
                frame_word_t word;
                word = '0;
                for (int s = 0; s < int'(DATA_SYMBOLS); s++)
                        word[2*s +: 2] = model_code(pattern[s]);
                return word;
        endfunction

        function automatic string kind_name(int kind);
                case (kind)
                        KIND_GOOD:    return "good";
                        KIND_MISSING: return "missing pulse";
                        default:      return "en low";
                endcase
        endfunction

        task automatic drive_sample(sample_t value, logic en_value);
                @(negedge clk);
                data_in = value;
                en      = en_value;
        endtask

        task automatic flag_error(string msg);
                $display("Fail at %0t ns: %s", $time, msg);
                row_errors = row_errors + 1;
        endtask

        task automatic send_frame(int row);
                logic en_pre;
                logic en_data;
                en_pre  = (kind_tab[row] != KIND_EN_LOW);
                // after an abort, data edges would look like frame starts
                en_data = (kind_tab[row] == KIND_GOOD);
                for (int sym = 0; sym < int'(PREAMBLE_SYMBOLS); sym++) begin
                        for (int i = 0; i < int'(SAMPLES_PER_SYMBOL); i++)
                                drive_sample(preamble_level(sym, i, kind_tab[row]), en_pre);
                end
                for (int sym = 0; sym < int'(DATA_SYMBOLS); sym++) begin
                        for (int i = 0; i < int'(SAMPLES_PER_SYMBOL); i++)
                                drive_sample(data_level(pattern_tab[row][sym], i), en_data);
                end
                last_data_cycle = cycle_count;
                repeat (IDLE_GAP) drive_sample(LEVEL_IDLE, 1'b0);
        endtask

        ////////////////////
        // main sequence
        ////////////////////

        initial begin
                frame_word_t expected;
                frame_word_t word_before;
                int          total_before;
                int unsigned rnd;
                rnd     = $urandom(16465);
                rst_n   = 1'b0;
                en      = 1'b0;
                data_in = LEVEL_IDLE;
                kind_tab   = '{KIND_GOOD, KIND_MISSING, KIND_EN_LOW, KIND_GOOD, KIND_GOOD};
                expect_tab = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
                for (int r = 0; r < ROWS; r++) begin
                        for (int s = 0; s < int'(DATA_SYMBOLS); s++) begin
                                rnd = $urandom();
                                pattern_tab[r][s] = rnd[0];
                        end
                end
                repeat (16) @(negedge clk);
                rst_n = 1'b1;

                row_errors = 0;
                repeat (4) drive_sample(LEVEL_IDLE, 1'b0);
                if (frame_valid !== 1'b0 || data_out !== '0 || valid_total != 0)
                        flag_error("outputs not idle after reset");
                errors = errors + row_errors;
                if (row_errors == 0)
                        passed_tests = passed_tests + 1;
                $display("reset check: %s", (row_errors == 0) ? "ok" : "failed");

                for (int row = 0; row < ROWS; row++) begin
                        row_errors   = 0;
                        total_before = valid_total;
                        word_before  = data_out;
                        expected     = model_word(pattern_tab[row]);
                        send_frame(row);
                        if (expect_tab[row]) begin
                                if (valid_total != total_before + 1)
                                        flag_error($sformatf("row %0d saw %0d frame_valid pulses",
                                                row, valid_total - total_before));
                                if (valid_cycle != last_data_cycle + 4)
                                        flag_error($sformatf("row %0d frame_valid %0d cycles late",
                                                row, valid_cycle - last_data_cycle));
                                if (valid_word !== expected)
                                        flag_error($sformatf("row %0d word %h expected %h",
                                                row, valid_word, expected));
                                if (data_out !== expected)
                                        flag_error($sformatf("row %0d data_out not held", row));
                                if (expected == word_before)
                                        flag_error($sformatf("row %0d word equals previous", row));
                        end else begin
                                if (valid_total != total_before)
                                        flag_error($sformatf("row %0d raised frame_valid", row));
                                if (data_out !== word_before)
                                        flag_error($sformatf("row %0d changed data_out", row));
                        end
                        errors = errors + row_errors;
                        if (row_errors == 0)
                                passed_tests = passed_tests + 1;
                        $display("row %0d (%s): %s", row, kind_name(kind_tab[row]),
                                (row_errors == 0) ? "ok" : "failed");
                end

                $display("tests passed %0d of %0d, errors %0d", passed_tests, ROWS + 1, errors);
                if (errors == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* hw/ppm_decoder_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ppm_decoder_top #(
        parameter int jump_threshold     = dsp_pkg::JUMP_THRESHOLD_DEFAULT,
        parameter int decision_threshold = dsp_pkg::DECISION_THRESHOLD_DEFAULT
) (
        input  wire  clk,
        input  wire  rst_n,
        input  wire  en,
        input  wire dsp_pkg::sample_t data_in,
        output frame_pkg::frame_word_t data_out,
        output logic frame_valid
);

        import dsp_pkg::*;
        import frame_pkg::*;

        sample_t     aligned_sample;
        logic        pulse;
        logic        data_sample;
        logic        symbol_last;
        sample_idx_t sample_idx;
        logic        frame_start;
        logic        code_valid;
        sym_code_t   code;

        ////////////////////
        // pipeline
        ////////////////////

        pulse_detector #(
                .jump_threshold (jump_threshold)
        ) u_pulse_detector (
                .clk            (clk),
                .rst_n          (rst_n),
                .data_in        (data_in),
                .aligned_sample (aligned_sample),
                .pulse          (pulse)
        );

        frame_sequencer u_frame_sequencer (
                .clk         (clk),
                .rst_n       (rst_n),
                .en          (en),
                .pulse       (pulse),
                .data_sample (data_sample),
                .symbol_last (symbol_last),
                .sample_idx  (sample_idx),
                .frame_start (frame_start)
        );

        symbol_correlator #(
                .decision_threshold (decision_threshold)
        ) u_symbol_correlator (
                .clk            (clk),
                .rst_n          (rst_n),
                .aligned_sample (aligned_sample),
                .data_sample    (data_sample),
                .symbol_last    (symbol_last),
                .sample_idx     (sample_idx),
                .code_valid     (code_valid),
                .code           (code)
        );

        code_packer u_code_packer (
                .clk         (clk),
                .rst_n       (rst_n),
                .frame_start (frame_start),
                .code_valid  (code_valid),
                .code        (code),
                .data_out    (data_out),
                .frame_valid (frame_valid)
        );

endmodule

`default_nettype wire

/* hw/code_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module code_packer (
        input  wire  clk,
        input  wire  rst_n,
        input  wire  frame_start,
        input  wire  code_valid,
        input  wire dsp_pkg::sym_code_t code,
        output frame_pkg::frame_word_t data_out,
        output logic frame_valid
);

        import frame_pkg::*;

        localparam symbol_idx_t LAST_CODE = symbol_idx_t'(DATA_SYMBOLS - 1);

        frame_word_t shift_q;
        frame_word_t shift_next;
        symbol_idx_t count_q;

        // newest code on top, first symbol ends in bits 1:0
        assign shift_next = {code, shift_q[FRAME_BITS-1:2]};

        always_ff @(posedge clk) begin
                if (code_valid)
                        shift_q <= shift_next;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        count_q     <= '0;
                        data_out    <= '0;
                        frame_valid <= 1'b0;
                end else begin
                        frame_valid <= 1'b0;
                        if (frame_start) begin
                                count_q <= '0;
                        end else if (code_valid) begin
                                if (count_q == LAST_CODE) begin
                                        data_out    <= shift_next;
                                        frame_valid <= 1'b1;
                                        count_q     <= '0;
                                end else begin
                                        count_q <= count_q + 7'd1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

/* hw/symbol_correlator.sv */
`timescale 1ns/100ps
`default_nettype none

module symbol_correlator #(
        parameter int decision_threshold = dsp_pkg::DECISION_THRESHOLD_DEFAULT
) (
        input  wire  clk,
        input  wire  rst_n,
        input  wire dsp_pkg::sample_t aligned_sample,
        input  wire  data_sample,
        input  wire  symbol_last,
        input  wire frame_pkg::sample_idx_t sample_idx,
        output logic code_valid,
        output dsp_pkg::sym_code_t code
);

        import dsp_pkg::*;

        corr_sum_t acc_q;
        corr_sum_t acc_base;
        corr_sum_t acc_next;
        corr_sum_t sample_ext;
        logic      template_bit;

        assign template_bit = CORR_TEMPLATE[sample_idx];
        assign sample_ext   = corr_sum_t'(aligned_sample);

        // fresh sum at the first sample of every symbol
        assign acc_base = (sample_idx == '0) ? '0 : acc_q;
        assign acc_next = template_bit ? (acc_base + sample_ext) : (acc_base - sample_ext);

        always_ff @(posedge clk) begin
                if (data_sample)
                        acc_q <= acc_next;
        end

        ////////////////////
        // decision
        ////////////////////

        // acc_next already holds sample 79 when symbol_last is high
        always_ff @(posedge clk) begin
                if (symbol_last)
                        code <= (acc_next > decision_threshold) ? CODE_HIGH : CODE_LOW;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        code_valid <= 1'b0;
                else
                        code_valid <= symbol_last;
        end

endmodule

`default_nettype wire

/* hw/frame_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer (
        input  wire  clk,
        input  wire  rst_n,
        input  wire  en,
        input  wire  pulse,
        output logic data_sample,
        output logic symbol_last,
        output frame_pkg::sample_idx_t sample_idx,
        output logic frame_start
);

        import frame_pkg::*;

        localparam sample_idx_t LAST_SAMPLE     = sample_idx_t'(SAMPLES_PER_SYMBOL - 1);
        localparam symbol_idx_t LAST_PRE_SYMBOL = symbol_idx_t'(PREAMBLE_SYMBOLS - 1);
        localparam symbol_idx_t LAST_SYMBOL     =
                symbol_idx_t'(PREAMBLE_SYMBOLS + DATA_SYMBOLS - 1);

        seq_state_t  state_q;
        sample_idx_t sample_q;
        symbol_idx_t symbol_q;
        logic        seen_q;

        logic start;
        logic symbol_end;
        logic in_window;
        logic window_end;
        logic window_ok;

        assign start      = en && pulse;
        assign symbol_end = (sample_q == LAST_SAMPLE);

        ////////////////////
        // preamble checkpoints
        ////////////////////

        // symbol 1 leading edge, symbols 3 and 4 at mid symbol
        assign in_window =
                ((symbol_q == 7'd1) && (sample_q <= 7'd2)) ||
                (((symbol_q == 7'd3) || (symbol_q == 7'd4)) &&
                 (sample_q >= 7'd39) && (sample_q <= 7'd41));

        assign window_end =
                ((symbol_q == 7'd1) && (sample_q == 7'd2)) ||
                (((symbol_q == 7'd3) || (symbol_q == 7'd4)) && (sample_q == 7'd41));

        assign window_ok = seen_q || pulse;

        ////////////////////
        // state machine
        ////////////////////

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state_q     <= ST_IDLE;
                        seen_q      <= 1'b0;
                        frame_start <= 1'b0;
                end else begin
                        frame_start <= 1'b0;
                        seen_q      <= 1'b0;
                        case (state_q)
                                ST_IDLE: begin
                                        if (start)
                                                state_q <= ST_PREAMBLE;
                                end
                                ST_PREAMBLE: begin
                                        seen_q <= in_window && window_ok;
                                        if (window_end && !window_ok) begin
                                                state_q <= ST_IDLE;
                                        end else if (symbol_end && symbol_q == LAST_PRE_SYMBOL) begin
                                                state_q     <= ST_DECODE;
                                                frame_start <= 1'b1;
                                        end
                                end
                                ST_DECODE: begin
                                        if (symbol_end && symbol_q == LAST_SYMBOL)
                                                state_q <= ST_DONE;
                                end
                                default: begin
                                        state_q <= ST_IDLE;
                                end
                        endcase
                end
        end

        // counters name the aligned sample of the current cycle
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sample_q <= '0;
                        symbol_q <= '0;
                end else if (state_q == ST_IDLE) begin
                        // the starting pulse itself is sample 0
                        sample_q <= start ? sample_idx_t'(1) : '0;
                        symbol_q <= '0;
                end else if (symbol_end) begin
                        sample_q <= '0;
                        symbol_q <= symbol_q + 7'd1;
                end else begin
                        sample_q <= sample_q + 7'd1;
                end
        end

        assign data_sample = (state_q == ST_DECODE);
        assign symbol_last = data_sample && symbol_end;
        assign sample_idx  = sample_q;

endmodule

`default_nettype wire

/* hw/pulse_detector.sv */
`timescale 1ns/100ps
`default_nettype none

module pulse_detector #(
        parameter int jump_threshold = dsp_pkg::JUMP_THRESHOLD_DEFAULT
) (
        input  wire             clk,
        input  wire             rst_n,
        input  wire dsp_pkg::sample_t data_in,
        output dsp_pkg::sample_t aligned_sample,
        output logic            pulse
);

        import dsp_pkg::*;

        sample_t data_d1;
        sample_t data_d2;

        logic signed [8:0] rise_diff;
        logic signed [8:0] next_diff;
        logic signed [8:0] next_abs;
        logic              edge_hit;

        // data_d1 is the sample under test, data_d2 before it, data_in after it
        assign rise_diff = $signed({1'b0, data_d1}) - $signed({1'b0, data_d2});
        assign next_diff = $signed({1'b0, data_in}) - $signed({1'b0, data_d1});
        assign next_abs  = (next_diff < 0) ? -next_diff : next_diff;

        // sharp rise that holds on the following sample
        assign edge_hit = (rise_diff > jump_threshold) && (next_abs < jump_threshold);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        data_d1 <= '0;
                        data_d2 <= '0;
                        pulse   <= 1'b0;
                end else begin
                        data_d1 <= data_in;
                        data_d2 <= data_d1;
                        // lands together with data_d2 holding the same sample
                        pulse   <= edge_hit;
                end
        end

        assign aligned_sample = data_d2;

endmodule

`default_nettype wire

/* hw/dsp_pkg.sv */
`default_nettype none

package dsp_pkg;

        ////////////////////
        // datapath types
        ////////////////////

        // raw sample from the converter, unsigned
        typedef logic [7:0] sample_t;

        // signed running sum, 80 x 255 fits with margin
        typedef logic signed [15:0] corr_sum_t;

        typedef logic [1:0] sym_code_t;

        localparam sym_code_t CODE_HIGH = 2'b10;
        localparam sym_code_t CODE_LOW  = 2'b01;

        ////////////////////
        // thresholds
        ////////////////////

        // minimum rise between neighbours for a pulse edge
        localparam int JUMP_THRESHOLD_DEFAULT     = 50;

        // correlation sum above this decodes as high
        localparam int DECISION_THRESHOLD_DEFAULT = 50;

        ////////////////////
        // correlation template
        ////////////////////

        // bit i set means add sample i, clear means subtract
        // first half of the symbol positive, second half negative
        localparam logic [79:0] CORR_TEMPLATE = {{40{1'b0}}, {40{1'b1}}};

endpackage

`default_nettype wire

/* hw/frame_pkg.sv */
`default_nettype none

package frame_pkg;

        ////////////////////
        // frame geometry
        ////////////////////

        localparam int unsigned SAMPLES_PER_SYMBOL = 80;
        localparam int unsigned PREAMBLE_SYMBOLS   = 7;
        localparam int unsigned DATA_SYMBOLS       = 112;

        // two code bits per data symbol
        localparam int unsigned FRAME_BITS         = 224;

        ////////////////////
        // counters and words
        ////////////////////

        // position inside one symbol, 0 to 79
        typedef logic [6:0] sample_idx_t;

        // symbol number across the whole frame, 0 to 118
        typedef logic [6:0] symbol_idx_t;

        typedef logic [FRAME_BITS-1:0] frame_word_t;

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_PREAMBLE,
                ST_DECODE,
                ST_DONE
        } seq_state_t;

endpackage

`default_nettype wire
